// File: verilog/cache_geom_pkg.sv
package cache_geom_pkg;

  localparam int addr_bits  = 32;
  localparam int s_offset   = 5;                           // byte within a line
  localparam int s_index    = 3;                           // set select
  localparam int s_tag      = addr_bits - s_offset - s_index;
  localparam int num_sets   = 2**s_index;
  localparam int num_ways   = 2;
  localparam int line_bytes = 2**s_offset;
  localparam int line_bits  = 8*line_bytes;

  // one address word, read either flat or split into its cache fields
  typedef union packed {
    logic [addr_bits-1:0] word;
    struct packed {
      logic [s_tag-1:0]    tag;
      logic [s_index-1:0]  index;
      logic [s_offset-1:0] offset;
    } f;
  } cache_addr_t;

endpackage

// File: verilog/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

  // data-array write status
  // bit 0 miss handling, bit 1 fetch address, bit 2 write the data array
  localparam int wstat_bits = 3;

  localparam logic [wstat_bits-1:0] wstat_idle      = 3'b000;
  localparam logic [wstat_bits-1:0] wstat_cpu_write = 3'b100;
  localparam logic [wstat_bits-1:0] wstat_writeback = 3'b001;
  localparam logic [wstat_bits-1:0] wstat_fetch     = 3'b011;
  localparam logic [wstat_bits-1:0] wstat_fill      = 3'b111;

  // control FSM states
  localparam int state_bits = 3;

  localparam logic [state_bits-1:0] st_idle      = 3'd0;
  localparam logic [state_bits-1:0] st_check     = 3'd1;
  localparam logic [state_bits-1:0] st_commit    = 3'd2;
  localparam logic [state_bits-1:0] st_writeback = 3'd3;
  localparam logic [state_bits-1:0] st_fetch     = 3'd4;
  localparam logic [state_bits-1:0] st_settle    = 3'd5;

endpackage

// File: verilog/dcache_ctrl_if.sv
`timescale 1ns/10ps

interface dcache_ctrl_if;
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;

  // control to datapath
  logic [num_ways-1:0]   ld_valid;
  logic                  valid_val;
  logic [num_ways-1:0]   ld_dirty;   // registered in the datapath
  logic                  dirty_val;
  logic                  ld_lru;     // registered in the datapath
  logic                  lru_val;
  logic [num_ways-1:0]   ld_tag;
  logic [wstat_bits-1:0] wstat;

  // datapath to control
  logic                  hit;
  logic                  way_hit;
  logic                  lru;        // way to replace next in this set
  logic [num_ways-1:0]   valid;
  logic [num_ways-1:0]   dirty;

  modport ctrl (
    output ld_valid, valid_val, ld_dirty, dirty_val, ld_lru, lru_val, ld_tag, wstat,
    input  hit, way_hit, lru, valid, dirty
  );

  modport dpath (
    input  ld_valid, valid_val, ld_dirty, dirty_val, ld_lru, lru_val, ld_tag, wstat,
    output hit, way_hit, lru, valid, dirty
  );

endinterface

// File: verilog/meta_array.sv
`timescale 1ns/10ps

module meta_array #(
  parameter int width = 1
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               load,
  input  logic [cache_geom_pkg::s_index-1:0] rindex,
  input  logic [cache_geom_pkg::s_index-1:0] windex,
  input  logic [width-1:0]                   datain,
  output logic [width-1:0]                   dataout
);
  import cache_geom_pkg::*;

  logic [width-1:0] entries [num_sets];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < num_sets; i++)
      begin
        entries[i] <= '0;
      end
    end
    else if (load)
    begin
      entries[windex] <= datain;
    end
  end

  assign dataout = entries[rindex];   // combinational read

endmodule

// File: verilog/line_array.sv
`timescale 1ns/10ps

module line_array (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [cache_geom_pkg::line_bytes-1:0] write_en,
  input  logic [cache_geom_pkg::s_index-1:0]    index,
  input  logic [cache_geom_pkg::line_bits-1:0]  datain,
  output logic [cache_geom_pkg::line_bits-1:0]  dataout
);
  import cache_geom_pkg::*;

  logic [line_bits-1:0] lines [num_sets];

  // writes are held off during reset
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      for (int b = 0; b < line_bytes; b++)
      begin
        if (write_en[b])
        begin
          lines[index][8*b +: 8] <= datain[8*b +: 8];
        end
      end
    end
  end

  assign dataout = lines[index];

endmodule

// File: verilog/dcache_datapath.sv
`timescale 1ns/10ps

module dcache_datapath (
  input  logic                                 clk,
  input  logic                                 rst,
  input  cache_geom_pkg::cache_addr_t          mem_address,
  input  logic [cache_geom_pkg::line_bits-1:0] mem_wdata256,
  input  logic [cache_geom_pkg::line_bytes-1:0] mem_byte_enable256,
  input  logic [cache_geom_pkg::line_bits-1:0] pmem_rdata,
  dcache_ctrl_if.dpath                         ctl,
  output logic [cache_geom_pkg::line_bits-1:0] mem_rdata256,
  output logic [cache_geom_pkg::addr_bits-1:0] pmem_address,
  output logic [cache_geom_pkg::line_bits-1:0] pmem_wdata
);
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;

  logic [num_ways-1:0][s_tag-1:0]      tag_out;
  logic [num_ways-1:0][line_bits-1:0]  line_out;
  logic [num_ways-1:0]                 match;

  logic [num_ways-1:0][line_bytes-1:0] we_next;
  logic [num_ways-1:0][line_bytes-1:0] we_q;
  logic [line_bits-1:0]                wdata_next;
  logic [line_bits-1:0]                wdata_q;

  logic [num_ways-1:0]                 ld_dirty_q;
  logic                                dirty_val_q;
  logic                                ld_lru_q;
  logic                                lru_val_q;

  cache_addr_t                         victim_addr;
  cache_addr_t                         fetch_addr;

  for (genvar w = 0; w < num_ways; w++)
  begin : g_way
    meta_array #(.width(1)) valid_arr (
      .clk     (clk),
      .rst     (rst),
      .load    (ctl.ld_valid[w]),
      .rindex  (mem_address.f.index),
      .windex  (mem_address.f.index),
      .datain  (ctl.valid_val),
      .dataout (ctl.valid[w])
    );

    meta_array #(.width(1)) dirty_arr (
      .clk     (clk),
      .rst     (rst),
      .load    (ld_dirty_q[w]),
      .rindex  (mem_address.f.index),
      .windex  (mem_address.f.index),
      .datain  (dirty_val_q),
      .dataout (ctl.dirty[w])
    );

    meta_array #(.width(s_tag)) tag_arr (
      .clk     (clk),
      .rst     (rst),
      .load    (ctl.ld_tag[w]),
      .rindex  (mem_address.f.index),
      .windex  (mem_address.f.index),
      .datain  (mem_address.f.tag),
      .dataout (tag_out[w])
    );

    line_array data_arr (
      .clk      (clk),
      .rst      (rst),
      .write_en (we_q[w]),
      .index    (mem_address.f.index),
      .datain   (wdata_q),
      .dataout  (line_out[w])
    );

    assign match[w] = ctl.valid[w] && (tag_out[w] == mem_address.f.tag);
  end

  meta_array #(.width(1)) lru_arr (
    .clk     (clk),
    .rst     (rst),
    .load    (ld_lru_q),
    .rindex  (mem_address.f.index),
    .windex  (mem_address.f.index),
    .datain  (lru_val_q),
    .dataout (ctl.lru)
  );

  assign ctl.hit     = |match;
  assign ctl.way_hit = match[1];
  assign mem_rdata256 = ctl.hit ? line_out[ctl.way_hit] : line_out[ctl.lru];
  assign pmem_wdata   = line_out[ctl.lru];   // victim line for write-back

  always_comb
  begin
    victim_addr          = '0;
    victim_addr.f.tag    = tag_out[ctl.lru];
    victim_addr.f.index  = mem_address.f.index;
    fetch_addr           = mem_address;
    fetch_addr.f.offset  = '0;               // line aligned

    we_next      = '0;
    wdata_next   = mem_wdata256;
    pmem_address = '0;

    if (ctl.wstat == wstat_cpu_write)
    begin
      we_next[ctl.way_hit] = mem_byte_enable256;
    end

    if (ctl.wstat[0])
    begin
      pmem_address = ctl.wstat[1] ? fetch_addr.word : victim_addr.word;
      // fill replaces the whole LRU line with the memory data
      if (ctl.wstat[2])
      begin
        we_next[ctl.lru] = '1;
        wdata_next       = pmem_rdata;
      end
    end
  end

  // array writes land one cycle after the status is presented
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      we_q       <= '0;
      ld_dirty_q <= '0;
      ld_lru_q   <= 1'b0;
    end
    else
    begin
      we_q       <= we_next;
      ld_dirty_q <= ctl.ld_dirty;
      ld_lru_q   <= ctl.ld_lru;
    end
  end

  always_ff @(posedge clk)
  begin
    wdata_q     <= wdata_next;
    dirty_val_q <= ctl.dirty_val;
    lru_val_q   <= ctl.lru_val;
  end

endmodule

// File: verilog/dcache_control.sv
`timescale 1ns/10ps

module dcache_control (
  input  logic        clk,
  input  logic        rst,
  input  logic        mem_read,
  input  logic        mem_write,
  input  logic        pmem_resp,
  dcache_ctrl_if.ctrl ctl,
  output logic        mem_resp,
  output logic        pmem_read,
  output logic        pmem_write
);
  import cache_ctrl_pkg::*;

  logic [state_bits-1:0] state;
  logic [state_bits-1:0] next_state;
  logic                  hit_seen;   // last check was a hit, so settle answers the CPU

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= st_idle;
      hit_seen <= 1'b0;
    end
    else
    begin
      state <= next_state;
      if (state == st_check)
      begin
        hit_seen <= ctl.hit;
      end
    end
  end

  always_comb
  begin
    next_state    = state;
    mem_resp      = 1'b0;
    pmem_read     = 1'b0;
    pmem_write    = 1'b0;
    ctl.wstat     = wstat_idle;
    ctl.ld_valid  = '0;
    ctl.valid_val = 1'b0;
    ctl.ld_dirty  = '0;
    ctl.dirty_val = 1'b0;
    ctl.ld_lru    = 1'b0;
    ctl.lru_val   = 1'b0;
    ctl.ld_tag    = '0;

    case (state)
      st_idle:
      begin
        if (mem_read || mem_write)
        begin
          next_state = st_check;
        end
      end

      st_check:
      begin
        if (ctl.hit)
        begin
          ctl.ld_lru  = 1'b1;
          ctl.lru_val = ~ctl.way_hit;   // other way becomes the victim
          if (mem_write)
          begin
            ctl.wstat                 = wstat_cpu_write;
            ctl.ld_dirty[ctl.way_hit] = 1'b1;
            ctl.dirty_val             = 1'b1;
            next_state                = st_commit;
          end
          else
          begin
            next_state = st_settle;
          end
        end
        else if (ctl.valid[ctl.lru] && ctl.dirty[ctl.lru])
        begin
          next_state = st_writeback;
        end
        else
        begin
          next_state = st_fetch;
        end
      end

      st_commit:
      begin
        next_state = st_settle;     // CPU write reaches the line this cycle
      end

      st_writeback:
      begin
        pmem_write = 1'b1;
        ctl.wstat  = wstat_writeback;
        if (pmem_resp)
        begin
          next_state = st_fetch;
        end
      end

      st_fetch:
      begin
        pmem_read = 1'b1;
        ctl.wstat = wstat_fetch;
        // pmem_rdata is only valid now, so capture it as a fill
        if (pmem_resp)
        begin
          ctl.wstat             = wstat_fill;
          ctl.ld_tag[ctl.lru]   = 1'b1;
          ctl.ld_valid[ctl.lru] = 1'b1;
          ctl.valid_val         = 1'b1;
          ctl.ld_dirty[ctl.lru] = 1'b1;
          ctl.dirty_val         = 1'b0;   // fresh line is clean
          next_state            = st_settle;
        end
      end

      st_settle:
      begin
        if (hit_seen)
        begin
          mem_resp   = 1'b1;
          next_state = st_idle;
        end
        else
        begin
          next_state = st_check;   // re-run the access, now as a hit
        end
      end

      default:
      begin
        next_state = st_idle;
      end
    endcase
  end

endmodule

// File: verilog/dcache.sv
`timescale 1ns/10ps

module dcache (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  mem_read,
  input  logic                                  mem_write,
  input  logic [cache_geom_pkg::addr_bits-1:0]  mem_address,
  input  logic [cache_geom_pkg::line_bits-1:0]  mem_wdata256,
  input  logic [cache_geom_pkg::line_bytes-1:0] mem_byte_enable256,
  output logic [cache_geom_pkg::line_bits-1:0]  mem_rdata256,
  output logic                                  mem_resp,
  input  logic [cache_geom_pkg::line_bits-1:0]  pmem_rdata,
  input  logic                                  pmem_resp,
  output logic                                  pmem_read,
  output logic                                  pmem_write,
  output logic [cache_geom_pkg::addr_bits-1:0]  pmem_address,
  output logic [cache_geom_pkg::line_bits-1:0]  pmem_wdata
);

  dcache_ctrl_if ctl_if ();

  dcache_control control (
    .clk        (clk),
    .rst        (rst),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .pmem_resp  (pmem_resp),
    .ctl        (ctl_if.ctrl),
    .mem_resp   (mem_resp),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write)
  );

  dcache_datapath datapath (
    .clk                (clk),
    .rst                (rst),
    .mem_address        (mem_address),
    .mem_wdata256       (mem_wdata256),
    .mem_byte_enable256 (mem_byte_enable256),
    .pmem_rdata         (pmem_rdata),
    .ctl                (ctl_if.dpath),
    .mem_rdata256       (mem_rdata256),
    .pmem_address       (pmem_address),
    .pmem_wdata         (pmem_wdata)
  );

endmodule

// File: bench/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb;
  import cache_geom_pkg::*;

  localparam int clk_period        = 20;
  localparam int num_tests         = 5;
  localparam int max_accesses      = 6;    // lru_replacement is the longest test
  localparam int worst_miss_cycles = 20;   // write-back plus fill at the slowest memory
  localparam int timeout_ns        =
    (2 + num_tests * max_accesses * worst_miss_cycles) * clk_period;
  localparam int max_lines         = 16;

  localparam logic [s_tag-1:0] tag_a = 24'h00a3c1;
  localparam logic [s_tag-1:0] tag_1 = 24'h1b0042;
  localparam logic [s_tag-1:0] tag_2 = 24'h2c7e10;
  localparam logic [s_tag-1:0] tag_3 = 24'h3d05f9;

  logic                  clk;
  logic                  rst;
  logic                  mem_read;
  logic                  mem_write;
  logic [addr_bits-1:0]  mem_address;
  logic [line_bits-1:0]  mem_wdata256;
  logic [line_bytes-1:0] mem_byte_enable256;
  logic [line_bits-1:0]  mem_rdata256;
  logic                  mem_resp;
  logic [line_bits-1:0]  pmem_rdata;
  logic                  pmem_resp;
  logic                  pmem_read;
  logic                  pmem_write;
  logic [addr_bits-1:0]  pmem_address;
  logic [line_bits-1:0]  pmem_wdata;

  // memory and reference share one slot table keyed by line address
  logic [addr_bits-1:0]  line_addr_tab [max_lines];
  logic [line_bits-1:0]  mem_lines [max_lines];
  logic [line_bits-1:0]  ref_lines [max_lines];
  int                    num_lines;

  logic [addr_bits-1:0]  fetch_log [$];
  logic [addr_bits-1:0]  wb_addr_log [$];
  logic [line_bits-1:0]  wb_data_log [$];

  int unsigned           seed;

  dcache dut (
    .clk                (clk),
    .rst                (rst),
    .mem_read           (mem_read),
    .mem_write          (mem_write),
    .mem_address        (mem_address),
    .mem_wdata256       (mem_wdata256),
    .mem_byte_enable256 (mem_byte_enable256),
    .mem_rdata256       (mem_rdata256),
    .mem_resp           (mem_resp),
    .pmem_rdata         (pmem_rdata),
    .pmem_resp          (pmem_resp),
    .pmem_read          (pmem_read),
    .pmem_write         (pmem_write),
    .pmem_address       (pmem_address),
    .pmem_wdata         (pmem_wdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(input string test_name, input logic [line_bits-1:0] expected,
                             input logic [line_bits-1:0] actual);
    if (expected !== actual)
    begin
      fail_run($sformatf("mismatch %s expected %h actual %h", test_name, expected, actual));
    end
  endtask

  function automatic logic [addr_bits-1:0] make_addr(input logic [s_tag-1:0] tag,
                                                     input logic [s_index-1:0] index,
                                                     input logic [s_offset-1:0] offset);
    cache_addr_t a;
    a.f.tag    = tag;
    a.f.index  = index;
    a.f.offset = offset;
    return a.word;
  endfunction

  function automatic logic [addr_bits-1:0] line_addr(input logic [addr_bits-1:0] addr);
    cache_addr_t a;
    a.word     = addr;
    a.f.offset = '0;
    return a.word;
  endfunction

  // a misaligned memory address matches no slot
  function automatic int slot_of(input logic [addr_bits-1:0] addr);
    int slot;
    slot = -1;
    for (int i = 0; i < num_lines; i++)
    begin
      if (line_addr_tab[i] == addr)
      begin
        slot = i;
      end
    end
    return slot;
  endfunction

  function automatic logic [line_bits-1:0] random_line();
    logic [line_bits-1:0] l;
    for (int w = 0; w < line_bits/32; w++)
    begin
      l[32*w +: 32] = $urandom;
    end
    return l;
  endfunction

  // enabled bytes take the new data, the rest keep the old line
  function automatic logic [line_bits-1:0] merge_bytes(input logic [line_bits-1:0] old_line,
                                                       input logic [line_bits-1:0] new_data,
                                                       input logic [line_bytes-1:0] be);
    logic [line_bits-1:0] merged;
    merged = old_line;
    for (int b = 0; b < line_bytes; b++)
    begin
      if (be[b])
      begin
        merged[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return merged;
  endfunction

  function automatic logic [line_bits-1:0] expected_line(input logic [addr_bits-1:0] addr);
    return ref_lines[slot_of(line_addr(addr))];
  endfunction

  task automatic seed_line(input logic [addr_bits-1:0] addr);
    logic [line_bits-1:0] l;
    l = random_line();
    line_addr_tab[num_lines] = line_addr(addr);
    mem_lines[num_lines]     = l;
    ref_lines[num_lines]     = l;   // memory and expected start equal
    num_lines++;
  endtask

  // memory model answers each held request after 1 to 4 cycles
  initial
  begin : memory_model
    int delay;
    int slot;
    delay = 0;
    forever
    begin
      @(negedge clk);
      if (pmem_resp)
      begin
        pmem_resp = 1'b0;
      end
      else if (pmem_read || pmem_write)
      begin
        if (delay == 0)
        begin
          delay = 1 + $urandom % 4;
        end
        delay--;
        if (delay == 0)
        begin
          slot = slot_of(pmem_address);
          if (slot < 0)
          begin
            fail_run($sformatf("memory access to unknown line address %h", pmem_address));
          end
          else if (pmem_write)
          begin
            mem_lines[slot] = pmem_wdata;
            wb_addr_log.push_back(pmem_address);
            wb_data_log.push_back(pmem_wdata);
            pmem_resp = 1'b1;
          end
          else
          begin
            pmem_rdata = mem_lines[slot];
            fetch_log.push_back(pmem_address);
            pmem_resp = 1'b1;
          end
        end
      end
    end
  end

  task automatic cpu_access(input logic is_write, input logic [addr_bits-1:0] addr,
                            input logic [line_bits-1:0] wdata,
                            input logic [line_bytes-1:0] be,
                            output logic [line_bits-1:0] rdata);
    @(negedge clk);
    mem_address        = addr;
    mem_wdata256       = wdata;
    mem_byte_enable256 = be;
    mem_read           = !is_write;
    mem_write          = is_write;
    @(negedge clk);
    while (!mem_resp)
    begin
      @(negedge clk);
    end
    rdata     = mem_rdata256;   // valid in the resp cycle
    mem_read  = 1'b0;
    mem_write = 1'b0;
  endtask

  task automatic read_and_check(input string test_name, input logic [addr_bits-1:0] addr);
    logic [line_bits-1:0] data;
    cpu_access(1'b0, addr, '0, '0, data);
    check_equal(test_name, expected_line(addr), data);
  endtask

  task automatic cpu_write(input logic [addr_bits-1:0] addr, input logic [line_bits-1:0] wdata,
                           input logic [line_bytes-1:0] be);
    logic [line_bits-1:0] unused;
    int slot;
    cpu_access(1'b1, addr, wdata, be, unused);
    slot = slot_of(line_addr(addr));
    ref_lines[slot] = merge_bytes(ref_lines[slot], wdata, be);
  endtask

  task automatic cold_read_miss();
    logic [addr_bits-1:0] a;
    int fetches;
    a = make_addr(tag_a, 3'd2, 5'h14);
    check_equal("cold_read_miss idle outputs", '0, {mem_resp, pmem_read, pmem_write});
    fetches = fetch_log.size();
    read_and_check("cold_read_miss data", a);
    check_equal("cold_read_miss fetch count", fetches + 1, fetch_log.size());
    check_equal("cold_read_miss fetch address", line_addr(a), fetch_log[fetch_log.size()-1]);
  endtask

  task automatic read_hit();
    int fetches;
    fetches = fetch_log.size();
    read_and_check("read_hit data", make_addr(tag_a, 3'd2, 5'h00));
    check_equal("read_hit fetch count", fetches, fetch_log.size());
  endtask

  task automatic write_hit_merge();
    logic [addr_bits-1:0] a;
    int fetches;
    a = make_addr(tag_a, 3'd2, 5'h08);
    fetches = fetch_log.size();
    cpu_write(a, random_line(), $urandom);
    read_and_check("write_hit_merge data", a);
    check_equal("write_hit_merge fetch count", fetches, fetch_log.size());
  endtask

  task automatic lru_replacement();
    int fetches;
    int wbs;
    wbs = wb_addr_log.size();
    read_and_check("lru_replacement first", make_addr(tag_1, 3'd5, 0));
    read_and_check("lru_replacement second", make_addr(tag_2, 3'd5, 0));
    read_and_check("lru_replacement first again", make_addr(tag_1, 3'd5, 0));
    read_and_check("lru_replacement third", make_addr(tag_3, 3'd5, 0));   // evicts second
    fetches = fetch_log.size();
    read_and_check("lru_replacement first kept", make_addr(tag_1, 3'd5, 0));
    check_equal("lru_replacement first no fetch", fetches, fetch_log.size());
    read_and_check("lru_replacement second refetch", make_addr(tag_2, 3'd5, 0));
    check_equal("lru_replacement second fetch", fetches + 1, fetch_log.size());
    check_equal("lru_replacement clean evictions", wbs, wb_addr_log.size());
  endtask

  task automatic dirty_writeback();
    logic [addr_bits-1:0] u1;
    int wbs;
    u1 = make_addr(tag_1, 3'd7, 0);
    read_and_check("dirty_writeback fill", u1);
    cpu_write(u1, random_line(), $urandom);
    read_and_check("dirty_writeback second way", make_addr(tag_2, 3'd7, 0));
    wbs = wb_addr_log.size();
    read_and_check("dirty_writeback evict", make_addr(tag_3, 3'd7, 0));
    check_equal("dirty_writeback count", wbs + 1, wb_addr_log.size());
    check_equal("dirty_writeback address", u1, wb_addr_log[wb_addr_log.size()-1]);
    check_equal("dirty_writeback data", expected_line(u1), wb_data_log[wb_data_log.size()-1]);
    wbs = wb_addr_log.size();
    read_and_check("dirty_writeback refetch", u1);   // evicts the clean line
    check_equal("dirty_writeback clean eviction", wbs, wb_addr_log.size());
  endtask

  initial
  begin : watchdog
    #(timeout_ns);
    fail_run($sformatf("timeout, the tests did not finish within %0d ns", timeout_ns));
  end

  initial
  begin
    seed = 32'h3f44;
    void'($urandom(seed));
    rst                = 1'b1;
    mem_read           = 1'b0;
    mem_write          = 1'b0;
    mem_address        = '0;
    mem_wdata256       = '0;
    mem_byte_enable256 = '0;
    pmem_rdata         = '0;
    pmem_resp          = 1'b0;
    num_lines          = 0;

    seed_line(make_addr(tag_a, 3'd2, 0));
    for (int s = 5; s <= 7; s += 2)
    begin
      seed_line(make_addr(tag_1, s, 0));
      seed_line(make_addr(tag_2, s, 0));
      seed_line(make_addr(tag_3, s, 0));
    end

    repeat (2) @(negedge clk);
    rst = 1'b0;

    cold_read_miss();
    read_hit();
    write_hit_merge();
    lru_replacement();
    dirty_writeback();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: list.f
verilog/cache_geom_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/dcache_ctrl_if.sv
verilog/meta_array.sv
verilog/line_array.sv
verilog/dcache_datapath.sv
verilog/dcache_control.sv
verilog/dcache.sv
bench/dcache_tb.sv
